/* hskbus_pkg.sv */
package hskbus_pkg;

    ////////////////////////////////////////////////////////////
    // Serial timing
    ////////////////////////////////////////////////////////////

    // Clock cycles per UART bit
    localparam int BAUD_PERIOD  = 16;
    // Retimer sample point
    // Late in the bit since the open-drain line rises slowly
    localparam int SAMPLE_POINT = 12;
    // Receiver sample point, mid-bit
    localparam int RX_MID_POINT = 8;
    // Start, eight data, stop
    localparam int FRAME_BITS   = 10;

    // Counter widths
    localparam int BAUD_CNT_W   = $clog2(BAUD_PERIOD);
    localparam int BIT_IDX_W    = $clog2(FRAME_BITS);

    ////////////////////////////////////////////////////////////
    // Byte buffer
    ////////////////////////////////////////////////////////////

    localparam int FIFO_DEPTH   = 4;
    localparam int FIFO_PTR_W   = 2;

    // One data byte
    typedef logic [7:0] hsk_byte_t;

    // Routing controls
    typedef struct packed {
        logic hsk_local;
        logic crate_enable;
        logic tctrl_b;
    } route_cfg_t;

    // Synchronized host-side receive lines
    typedef struct packed {
        logic dbg_rx;
        logic trx;
    } host_lines_t;

endpackage

/* hskbus_route.sv */
`timescale 1ns/10ps

module hskbus_route import hskbus_pkg::*; (
    input  logic       init_clk,
    input  logic       rst_n_i,
    input  route_cfg_t cfg_i,
    input  logic       dbg_rx_i,
    input  logic       trx_i,
    input  logic       surf_tx_i,
    input  logic       retimed_i,
    output logic       host_line_o,
    output logic       return_line_o,
    output logic       dbg_tx_o,
    output logic       f_ttx_o
);

    route_cfg_t  cfg_q;
    host_lines_t host_meta;
    host_lines_t host_sync;
    logic        surf_meta;
    logic        surf_sync;
    logic        host_sel;

    ////////////////////////////////////////////////////////////
    // Config register and line synchronizers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            cfg_q     <= '0;
            // Lines idle high
            host_meta <= '1;
            host_sync <= '1;
            surf_meta <= 1'b1;
            surf_sync <= 1'b1;
        end else begin
            cfg_q     <= cfg_i;
            host_meta <= '{dbg_rx: dbg_rx_i, trx: trx_i};
            host_sync <= host_meta;
            surf_meta <= surf_tx_i;
            surf_sync <= surf_meta;
        end
    end

    // Host source select
    // Debug UART in local mode, TURF only while its control is low
    always_comb begin
        if (!cfg_q.crate_enable) begin
            host_sel = 1'b1;
        end else if (cfg_q.hsk_local) begin
            host_sel = host_sync.dbg_rx;
        end else if (!cfg_q.tctrl_b) begin
            host_sel = host_sync.trx;
        end else begin
            host_sel = 1'b1;
        end
    end

    // Output flops for both crate-bound lines
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            host_line_o   <= 1'b1;
            return_line_o <= 1'b1;
        end else begin
            host_line_o   <= host_sel;
            // Disabled crate looks like an idle SURF
            return_line_o <= cfg_q.crate_enable ? surf_sync : 1'b1;
        end
    end

    // Return steering, unselected side idles high
    assign dbg_tx_o = cfg_q.hsk_local ? retimed_i : 1'b1;
    assign f_ttx_o  = cfg_q.hsk_local ? 1'b1 : retimed_i;

endmodule

/* uart_byte_rx.sv */
`timescale 1ns/10ps

module uart_byte_rx import hskbus_pkg::*; (
    input  logic       init_clk,
    input  logic       rst_n_i,
    input  logic       line_i,
    output logic       byte_valid_o,
    output hsk_byte_t  byte_o,
    output logic [7:0] rx_bytes_o
);

    logic                  line_q;
    logic                  active;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    hsk_byte_t             shift_q;
    logic                  sample_now;
    logic                  start_bit;
    logic                  stop_bit;

    // Mid-bit strobe while a frame is in progress
    assign sample_now = active && (baud_cnt == BAUD_CNT_W'(RX_MID_POINT));
    assign start_bit  = (bit_idx == '0);
    assign stop_bit   = (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));
    assign byte_o     = shift_q;

    ////////////////////////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            line_q       <= 1'b1;
            active       <= 1'b0;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            byte_valid_o <= 1'b0;
            rx_bytes_o   <= '0;
        end else begin
            line_q       <= line_i;
            byte_valid_o <= 1'b0;
            if (!active) begin
                // Falling edge on an idle line
                if (line_q && !line_i) begin
                    active   <= 1'b1;
                    // Edge cycle counts as cycle 0 of the start bit
                    baud_cnt <= BAUD_CNT_W'(1);
                    bit_idx  <= '0;
                end
            end else begin
                if (baud_cnt == BAUD_CNT_W'(BAUD_PERIOD - 1)) begin
                    baud_cnt <= '0;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
                if (sample_now) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (start_bit && line_i) begin
                        // Glitch, not a real start
                        active <= 1'b0;
                    end else if (stop_bit) begin
                        active <= 1'b0;
                        // Low stop bit drops the byte
                        if (line_i) begin
                            byte_valid_o <= 1'b1;
                            rx_bytes_o   <= rx_bytes_o + 8'd1;
                        end
                    end
                end
            end
        end
    end

    // Data bits, LSB first
    always_ff @(posedge init_clk) begin
        if (sample_now && !start_bit && !stop_bit) begin
            shift_q <= {line_i, shift_q[7:1]};
        end
    end

    // Frames are 160 cycles apart, valid never stretches
    a_valid_pulse: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        byte_valid_o |=> !byte_valid_o)
        else $error("byte_valid held longer than one cycle");

endmodule

/* byte_fifo.sv */
`timescale 1ns/10ps

module byte_fifo import hskbus_pkg::*; (
    input  logic      init_clk,
    input  logic      rst_n_i,
    input  logic      push_i,
    input  hsk_byte_t data_i,
    input  logic      pop_i,
    output hsk_byte_t data_o,
    output logic      empty_o
);

    hsk_byte_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (int'(count) == FIFO_DEPTH);
    assign empty_o = (count == '0);
    // Overflow push is dropped
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    // Head of queue
    assign data_o  = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge init_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Receiver rate never exceeds transmitter rate
    a_no_overflow: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        push_i |-> !full)
        else $error("byte pushed into full buffer and lost");

    // Consumer must respect empty
    a_no_underflow: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        pop_i |-> !empty_o)
        else $error("pop from empty buffer");

endmodule

/* uart_byte_tx.sv */
`timescale 1ns/10ps

module uart_byte_tx import hskbus_pkg::*; (
    input  logic      init_clk,
    input  logic      rst_n_i,
    input  logic      empty_i,
    input  hsk_byte_t data_i,
    output logic      pop_o,
    output logic      line_o
);

    logic                  busy;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [FRAME_BITS-1:0] frame_q;
    logic                  bit_end;
    logic                  frame_end;

    // Last cycle of each bit
    assign bit_end   = (baud_cnt == BAUD_CNT_W'(BAUD_PERIOD - 1));
    // Last cycle of the stop bit
    assign frame_end = busy && bit_end && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));

    // Pop when idle or on the final stop cycle
    // Next start bit then follows with no gap
    assign pop_o  = !empty_i && (!busy || frame_end);
    assign line_o = busy ? frame_q[0] : 1'b1;

    ////////////////////////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (busy) begin
                if (bit_end) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
                if (frame_end) begin
                    busy <= 1'b0;
                end
            end
            // New frame overrides the end of the old one
            if (pop_o) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end
    end

    // Frame shifter, stop in the MSB, start in the LSB
    always_ff @(posedge init_clk) begin
        if (pop_o) begin
            frame_q <= {1'b1, data_i, 1'b0};
        end else if (busy && bit_end) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

endmodule

/* surf_tx_retimer.sv */
`timescale 1ns/10ps

module surf_tx_retimer import hskbus_pkg::*; (
    input  logic init_clk,
    input  logic rst_n_i,
    input  logic line_i,
    output logic retimed_o
);

    logic                  line_q;
    logic                  armed;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic                  start_edge;
    logic                  in_tail;
    logic                  sample_now;

    assign start_edge = line_q && !line_i;
    // Stop bit sampled, now holding it
    assign in_tail    = (bit_idx == BIT_IDX_W'(FRAME_BITS));
    // Late sample point, line has settled by now
    assign sample_now = armed && (baud_cnt == BAUD_CNT_W'(SAMPLE_POINT));

    ////////////////////////////////////////////////////////////
    // Edge detect, sample and re-emit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            line_q    <= 1'b1;
            armed     <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            retimed_o <= 1'b1;
        end else begin
            line_q <= line_i;
            if (armed) begin
                if (baud_cnt == BAUD_CNT_W'(BAUD_PERIOD - 1)) begin
                    baud_cnt <= '0;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
            // Back-to-back frames re-arm during the stop hold
            if (start_edge && (!armed || in_tail)) begin
                armed    <= 1'b1;
                baud_cnt <= BAUD_CNT_W'(1);
                bit_idx  <= '0;
            end else if (sample_now) begin
                if (in_tail) begin
                    // Full stop bit done, back to idle
                    armed     <= 1'b0;
                    retimed_o <= 1'b1;
                end else if ((bit_idx == '0) && line_i) begin
                    // Start bit gone, treat as glitch
                    armed <= 1'b0;
                end else begin
                    // Held until the next sample, one bit period
                    retimed_o <= line_i;
                    bit_idx   <= bit_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* hskbus_bridge.sv */
`timescale 1ns/10ps

module hskbus_bridge import hskbus_pkg::*; (
    input  logic       init_clk,
    input  logic       rst_n_i,
    input  route_cfg_t cfg_i,
    input  logic       dbg_rx_i,
    input  logic       trx_i,
    input  logic       surf_tx_i,
    output logic       dbg_tx_o,
    output logic       f_ttx_o,
    output logic       surf_rx_o,
    output logic [7:0] rx_bytes_o
);

    // Host side to crate
    logic      host_line;
    logic      byte_valid;
    hsk_byte_t rx_byte;
    hsk_byte_t head_byte;
    logic      fifo_empty;
    logic      tx_pop;

    // Crate back to host side
    logic      return_line;
    logic      retimed;

    ////////////////////////////////////////////////////////////
    // Routing and enable
    ////////////////////////////////////////////////////////////

    hskbus_route u_route (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .cfg_i         (cfg_i),
        .dbg_rx_i      (dbg_rx_i),
        .trx_i         (trx_i),
        .surf_tx_i     (surf_tx_i),
        .retimed_i     (retimed),
        .host_line_o   (host_line),
        .return_line_o (return_line),
        .dbg_tx_o      (dbg_tx_o),
        .f_ttx_o       (f_ttx_o)
    );

    // Forward path, receive then buffer then resend
    uart_byte_rx u_rx (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n_i),
        .line_i       (host_line),
        .byte_valid_o (byte_valid),
        .byte_o       (rx_byte),
        .rx_bytes_o   (rx_bytes_o)
    );

    byte_fifo u_fifo (
        .init_clk (init_clk),
        .rst_n_i  (rst_n_i),
        .push_i   (byte_valid),
        .data_i   (rx_byte),
        .pop_i    (tx_pop),
        .data_o   (head_byte),
        .empty_o  (fifo_empty)
    );

    uart_byte_tx u_tx (
        .init_clk (init_clk),
        .rst_n_i  (rst_n_i),
        .empty_i  (fifo_empty),
        .data_i   (head_byte),
        .pop_o    (tx_pop),
        .line_o   (surf_rx_o)
    );

    // Return path
    surf_tx_retimer u_retimer (
        .init_clk  (init_clk),
        .rst_n_i   (rst_n_i),
        .line_i    (return_line),
        .retimed_o (retimed)
    );

endmodule

/* tb_hskbus_tasks.svh */
`ifndef TB_HSKBUS_TASKS_SVH
`define TB_HSKBUS_TASKS_SVH

    // Result counters
    int          error_count  = 0;
    int          checks_run   = 0;
    int          tests_failed = 0;
    // Good bytes expected so far, from the golden increments
    logic [7:0]  exp_bytes    = 8'd0;
    // Fibonacci LFSR state
    logic [31:0] lfsr_q       = 32'h8817_86d8;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    // Decoded serial byte
    task automatic check_byte(input string name, input hsk_byte_t got, input hsk_byte_t exp);
        checks_run++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED t=%0t %0s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    // Good-byte counter
    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks_run++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED t=%0t %0s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Idle line level, high expected
    task automatic check_idle(input string name, input logic got, output bit ok);
        checks_run++;
        ok = (got === 1'b1);
        if (!ok) begin
            error_count++;
            $display("CHECK FAILED t=%0t %0s got %b expected 1", $time, name, got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pseudo-random gaps
    ////////////////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = next_lfsr(lfsr_q);
            v      = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

`endif

/* tb_hskbus_bridge.sv */
`timescale 1ns/10ps

module tb_hskbus_bridge import hskbus_pkg::*; ();

    localparam int NUM_TESTS    = 10;
    // Tokens per golden line
    localparam int NUM_FIELDS   = 12;
    localparam int FRAME_CYCLES = BAUD_PERIOD * FRAME_BITS;
    // Four frame times per test plus slack for reset and gaps
    localparam int CYCLE_LIMIT  = NUM_TESTS * 4 * FRAME_CYCLES + 2000;

    logic       init_clk;
    logic       rst_n_i;
    route_cfg_t cfg_i;
    logic       dbg_rx_i;
    logic       trx_i;
    logic       surf_tx_i;
    logic       dbg_tx_o;
    logic       f_ttx_o;
    logic       surf_rx_o;
    logic [7:0] rx_bytes_o;

    logic [7:0] golden [NUM_TESTS*NUM_FIELDS];
    // Host bytes of the current test
    hsk_byte_t  test_bytes [3];
    int         cycle_cnt = 0;

    `include "tb_hskbus_tasks.svh"

    hskbus_bridge u_dut (
        .init_clk   (init_clk),
        .rst_n_i    (rst_n_i),
        .cfg_i      (cfg_i),
        .dbg_rx_i   (dbg_rx_i),
        .trx_i      (trx_i),
        .surf_tx_i  (surf_tx_i),
        .dbg_tx_o   (dbg_tx_o),
        .f_ttx_o    (f_ttx_o),
        .surf_rx_o  (surf_rx_o),
        .rx_bytes_o (rx_bytes_o)
    );

    // 100 ns clock
    initial begin
        init_clk = 1'b0;
        forever #50 init_clk = ~init_clk;
    end

    // Global run limit
    always @(posedge init_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles before all tests finished", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Line access
    ////////////////////////////////////////////////////////////

    // 0 debug rx, 1 TURF rx, 2 SURF tx
    task automatic put_pin(input int pin, input logic level);
        case (pin)
            0:       dbg_rx_i  = level;
            1:       trx_i     = level;
            default: surf_tx_i = level;
        endcase
    endtask

    // 0 SURF rx, 1 debug tx, 2 TURF tx
    function automatic logic line_level(input int sel);
        case (sel)
            0:       return surf_rx_o;
            1:       return dbg_tx_o;
            default: return f_ttx_o;
        endcase
    endfunction

    function automatic string line_name(input int sel);
        case (sel)
            0:       return "surf_rx_o";
            1:       return "dbg_tx_o";
            default: return "f_ttx_o";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Serial driver and decoder
    ////////////////////////////////////////////////////////////

    // Entered 10 ns after a rising edge, LSB first
    task automatic send_frame(input int pin, input hsk_byte_t data, input bit stop_ok);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop_ok, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            put_pin(pin, bits[i]);
            repeat (BAUD_PERIOD) @(posedge init_clk);
            #10;
        end
        // Back to idle after a bad stop
        put_pin(pin, 1'b1);
    endtask

    // No gap between frames
    task automatic send_burst(input int pin, input int n, input bit invert, input bit stop_ok);
        for (int i = 0; i < n; i++) begin
            send_frame(pin, invert ? ~test_bytes[i] : test_bytes[i], stop_ok);
        end
    endtask

    // Sampled on falling edges, away from output updates
    task automatic decode_frame(input int sel, input int limit, output hsk_byte_t data,
                                output bit found, output int used);
        bit stop_high;
        found = 1'b0;
        used  = 0;
        data  = '0;
        while (!found && used < limit) begin
            @(negedge init_clk);
            used++;
            found = (line_level(sel) == 1'b0);
        end
        if (found) begin
            // Centre of start bit, then one bit period per sample
            repeat (BAUD_PERIOD / 2) @(negedge init_clk);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_PERIOD) @(negedge init_clk);
                data[i] = line_level(sel);
            end
            repeat (BAUD_PERIOD) @(negedge init_clk);
            // Stop bit must be high
            check_idle(line_name(sel), line_level(sel), stop_high);
            used += BAUD_PERIOD / 2 + 9 * BAUD_PERIOD;
        end
    endtask

    // Expected frames in order, then idle until the window ends
    task automatic monitor_line(input int sel, input int n_exp, input logic [23:0] exp_seq,
                                input int window);
        hsk_byte_t data;
        bit        found;
        bit        ok;
        int        used;
        int        left;
        left = window;
        for (int i = 0; i < n_exp; i++) begin
            decode_frame(sel, left, data, found, used);
            left -= used;
            if (!found) begin
                error_count++;
                $display("No frame on %0s within %0d cycles, t=%0t", line_name(sel), window,
                         $time);
                return;
            end
            check_byte(line_name(sel), data, exp_seq[8*i +: 8]);
        end
        ok = 1'b1;
        while (ok && left > 0) begin
            @(negedge init_clk);
            left--;
            check_idle(line_name(sel), line_level(sel), ok);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One golden line
    ////////////////////////////////////////////////////////////

    task automatic run_test(input int t);
        int         base;
        int         pin;
        int         n_frm;
        int         gap;
        int         window;
        int         errs_before;
        bit         stop_ok;
        bit         ret_en;
        hsk_byte_t  ret_byte;
        base          = t * NUM_FIELDS;
        pin           = int'(golden[base+1]);
        n_frm         = int'(golden[base+2]);
        test_bytes[0] = golden[base+3];
        test_bytes[1] = golden[base+4];
        test_bytes[2] = golden[base+5];
        stop_ok       = golden[base+6][0];
        ret_en        = golden[base+7][0];
        ret_byte      = golden[base+8];
        errs_before   = error_count;
        // Random idle gap, then new routing
        gap = random_bits(3);
        repeat (gap + 1) @(posedge init_clk);
        #10;
        cfg_i = route_cfg_t'(golden[base][2:0]);
        repeat (4) @(posedge init_clk);
        #10;
        exp_bytes = exp_bytes + golden[base+11];
        // Long enough for the last frame to be received and resent
        window = (n_frm + 2) * FRAME_CYCLES + 40;
        fork
            send_burst(pin, n_frm, 1'b0, stop_ok);
            // Same bytes inverted on the other host pin
            send_burst(1 - pin, n_frm, 1'b1, 1'b1);
            if (ret_en) send_frame(2, ret_byte, 1'b1);
            monitor_line(0, int'(golden[base+9]),
                         {test_bytes[2], test_bytes[1], test_bytes[0]}, window);
            monitor_line(1, (golden[base+10] == 8'd1) ? 1 : 0, {16'h0, ret_byte}, window);
            monitor_line(2, (golden[base+10] == 8'd2) ? 1 : 0, {16'h0, ret_byte}, window);
        join
        @(negedge init_clk);
        check_count("rx_bytes_o", rx_bytes_o, exp_bytes);
        if (error_count == errs_before) begin
            $display("test %0d cfg %03b ok", t, cfg_i);
        end else begin
            tests_failed++;
            $display("test %0d cfg %03b failed", t, cfg_i);
        end
        @(posedge init_clk);
        #10;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        bit reset_ok;
        rst_n_i   = 1'b0;
        cfg_i     = '0;
        dbg_rx_i  = 1'b1;
        trx_i     = 1'b1;
        surf_tx_i = 1'b1;
        $readmemh("hskbus_golden.txt", golden);
        repeat (8) @(posedge init_clk);
        #10;
        rst_n_i = 1'b1;
        // Every line idle and counter clear out of reset
        @(negedge init_clk);
        check_idle("surf_rx_o", surf_rx_o, reset_ok);
        check_idle("dbg_tx_o", dbg_tx_o, reset_ok);
        check_idle("f_ttx_o", f_ttx_o, reset_ok);
        check_count("rx_bytes_o", rx_bytes_o, 8'd0);
        @(posedge init_clk);
        #10;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, tests_failed,
                 checks_run, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* hskbus_golden.txt */
// cfg pin nfrm b0 b1 b2 stop ret_en ret_byte exp_fwd exp_ret exp_inc
// cfg = local,enable,tctrl_b; pin 0 debug 1 TURF; exp_ret 0 none 1 debug 2 TURF
// Local mode, forward only
6 0 1 A5 00 00 1 0 00 1 0 1
// Local mode, forward and return together
6 0 1 3C 00 00 1 1 5A 1 1 1
// TURF mode with control low
2 1 1 C3 00 00 1 1 81 1 2 1
// TURF mode with control high, host path gated
3 1 1 7E 00 00 1 1 42 0 2 0
// Crate disabled, local then TURF
4 0 1 99 00 00 1 1 66 0 0 0
0 1 1 11 00 00 1 1 EE 0 0 0
// Low stop bit, local then TURF
6 0 1 B2 00 00 0 0 00 0 0 0
2 1 1 4D 00 00 0 1 18 0 2 0
// Three frames back to back
6 0 3 01 80 FF 1 1 A7 3 1 3
2 1 3 55 AA 00 1 1 24 3 2 3

/* hskbus_bridge.f */
+incdir+.
hskbus_pkg.sv
hskbus_route.sv
uart_byte_rx.sv
byte_fifo.sv
uart_byte_tx.sv
surf_tx_retimer.sv
hskbus_bridge.sv
tb_hskbus_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench, pass only if the pass line is printed
verilator --binary --timing --assert --top-module tb_hskbus_bridge \
    -f hskbus_bridge.f -o tb_hskbus_bridge \
    && ./obj_dir/tb_hskbus_bridge | tee /dev/stderr | grep -q '^NO ERRORS$' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
